/* source/sce_pkg.sv */
// ----------------------------------------------------------------------
// sizes, segment table and channel structs of the scratch engine
// segment table is tied to AW and SEGCNT, resize them together
// segment index is the top SEGW address bits
// ----------------------------------------------------------------------
package sce_pkg;

    localparam int AW       = 8;
    localparam int DW       = 32;
    localparam int RAMDEPTH = 256;
    localparam int SEGCNT   = 4;
    localparam int SEGW     = $clog2(SEGCNT);
    localparam int CHNLCNT  = 3;
    localparam int CHW      = $clog2(CHNLCNT);
    localparam int LENW     = 9;
    localparam int EXTCNT   = 16;
    localparam int EXTW     = $clog2(EXTCNT);

    // channel slots
    localparam int CH_HOST = 0;
    localparam int CH_COPY = 1;
    localparam int CH_FILL = 2;

    // allowed segments per channel in secure mode, bit n is segment n
    localparam logic [CHNLCNT-1:0][SEGCNT-1:0] SEG_ALLOW = {
        4'b1100,   // fill
        4'b0110,   // copy
        4'b0011    // host
    };

    typedef struct packed {
        logic          rd;
        logic          wr;
        logic [AW-1:0] addr;
        logic [DW-1:0] wdat;
    } chnlreq_t;

    typedef struct packed {
        logic          ready;
        logic          err;
        logic [DW-1:0] rdat;
    } chnlres_t;

    typedef struct packed {
        logic [AW-1:0]   src;
        logic [AW-1:0]   dst;
        logic [LENW-1:0] len;
    } xfer_cmd_t;

    typedef struct packed {
        logic [AW-1:0]   dst;
        logic [LENW-1:0] len;
        logic [DW-1:0]   value;
    } fill_cmd_t;

endpackage

/* source/sce_resetgen.sv */
// ----------------------------------------------------------------------
// reset extender for the engine
// rst_n stays low while arst_n is low or soft_reset is high, and for
// EXTCNT clocks after both are released
// soft_reset acts asynchronously, so it must be glitch free
// ----------------------------------------------------------------------
module sce_resetgen
    import sce_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic soft_reset,
    output logic rst_n
);

    logic            rst_in_n;
    logic [EXTW-1:0] ext_cnt;
    logic            ext_hit;

    // either source holds the extender in reset
    assign rst_in_n = arst_n & ~soft_reset;

    assign ext_hit = (ext_cnt == EXTW'(EXTCNT - 1));

    always_ff @(posedge clk or negedge rst_in_n) begin
        if (!rst_in_n) begin
            ext_cnt <= '0;
            rst_n   <= 1'b0;
        end else begin
            // count stops at the last value
            if (!ext_hit)
                ext_cnt <= ext_cnt + 1'b1;
            rst_n <= ext_hit;
        end
    end

endmodule

/* source/sce_ac.sv */
// ----------------------------------------------------------------------
// segment access control in front of the memory controller
// secure mode confines each channel to its SEG_ALLOW segments
// a denied request never reaches the controller and is answered here
// one cycle later with ready and err high and rdat zero
// masters must hold a request until ready, as the channel protocol says
// ----------------------------------------------------------------------
module sce_ac
    import sce_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       secmode,
    input  chnlreq_t [CHNLCNT-1:0]     in_req,
    output chnlres_t [CHNLCNT-1:0]     in_res,
    output chnlreq_t [CHNLCNT-1:0]     out_req,
    input  chnlres_t [CHNLCNT-1:0]     out_res,
    output logic     [CHNLCNT-1:0]     acerr
);

    logic [CHNLCNT-1:0] deny;
    logic [CHNLCNT-1:0] deny_q;

    always_comb begin
        for (int i = 0; i < CHNLCNT; i++) begin
            // segment check only for an active request
            deny[i] = secmode && (in_req[i].rd || in_req[i].wr)
                      && !SEG_ALLOW[i][in_req[i].addr[AW-1 -: SEGW]];
            // masked request looks idle to the controller
            out_req[i] = deny[i] ? '0 : in_req[i];
            in_res[i]  = out_res[i];
            // local answer for the denied access
            if (deny_q[i]) begin
                in_res[i].ready = 1'b1;
                in_res[i].err   = 1'b1;
                in_res[i].rdat  = '0;
            end
        end
    end

    // request is still held in the answer cycle
    // so skip one cycle after each answer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            deny_q <= '0;
        else
            deny_q <= deny & ~deny_q;
    end

    assign acerr = deny_q;

endmodule

/* source/sce_memc.sv */
// ----------------------------------------------------------------------
// round-robin memory controller for the scratch RAM
// one access per two cycles, grant cycle then response cycle
// no grants while the RAM clear sweep runs
// a response carries no err, denials are answered by access control
// ----------------------------------------------------------------------
module sce_memc
    import sce_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  chnlreq_t [CHNLCNT-1:0] req,
    output chnlres_t [CHNLCNT-1:0] res,
    output logic     [AW-1:0]      ram_addr,
    output logic                   ram_rd,
    output logic                   ram_wr,
    output logic     [DW-1:0]      ram_wdat,
    input  logic     [DW-1:0]      ram_rdat,
    input  logic                   clr_busy
);

    logic           resp;
    logic [CHW-1:0] last;
    logic [CHW-1:0] pick;
    logic           pick_vld;
    logic           grant;
    chnlreq_t       sel_req;

    // search starts right after the last granted channel
    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick     = last;
        for (int k = 1; k <= CHNLCNT; k++) begin
            idx = (int'(last) + k) % CHNLCNT;
            if (!pick_vld && (req[idx].rd || req[idx].wr)) begin
                pick_vld = 1'b1;
                pick     = CHW'(idx);
            end
        end
    end

    assign grant   = !resp && !clr_busy && pick_vld;
    assign sel_req = req[pick];

    // strobes only in the grant cycle
    assign ram_addr = sel_req.addr;
    assign ram_wdat = sel_req.wdat;
    assign ram_rd   = grant && sel_req.rd;
    assign ram_wr   = grant && sel_req.wr;

    // last doubles as the response target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp <= 1'b0;
            last <= CHW'(CHNLCNT - 1);
        end else begin
            resp <= grant;
            if (grant)
                last <= pick;
        end
    end

    // ready and read data to the granted channel only
    always_comb begin
        for (int i = 0; i < CHNLCNT; i++) begin
            res[i]       = '0;
            res[i].ready = resp && (last == CHW'(i));
            res[i].rdat  = res[i].ready ? ram_rdat : '0;
        end
    end

endmodule

/* source/sce_ram.sv */
// ----------------------------------------------------------------------
// single-port scratch RAM, registered read data
// clr starts a sweep writing zero to one word per cycle
// clr_busy is high for RAMDEPTH cycles, no access may be issued then
// clr during a running sweep is ignored
// ----------------------------------------------------------------------
module sce_ram
    import sce_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic [AW-1:0] addr,
    input  logic          rd,
    input  logic          wr,
    input  logic [DW-1:0] wdat,
    output logic [DW-1:0] rdat,
    input  logic          clr,
    output logic          clr_busy
);

    logic [DW-1:0] mem [RAMDEPTH];
    logic [AW-1:0] clr_cnt;

    // sweep control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr_busy <= 1'b0;
            clr_cnt  <= '0;
        end else if (clr_busy) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == AW'(RAMDEPTH - 1))
                clr_busy <= 1'b0;
        end else if (clr) begin
            clr_busy <= 1'b1;
            clr_cnt  <= '0;
        end
    end

    // array and read port
    always_ff @(posedge clk) begin
        if (clr_busy)
            mem[clr_cnt] <= '0;
        else if (wr)
            mem[addr] <= wdat;
        if (rd)
            rdat <= mem[addr];
    end

endmodule

/* source/sce_copy.sv */
// ----------------------------------------------------------------------
// copy engine, one channel, read then write for each word
// cmd.len must be 1 to 256, addresses wrap at the end of the RAM
// stops at the first err response, later words are not written
// start is ignored while busy
// ----------------------------------------------------------------------
module sce_copy
    import sce_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  xfer_cmd_t cmd,
    output chnlreq_t  req,
    input  chnlres_t  res,
    output logic      busy,
    output logic      done,
    output logic      err
);

    typedef enum logic [1:0] {ST_IDLE, ST_RD, ST_WR} state_t;

    state_t          state;
    logic [AW-1:0]   src;
    logic [AW-1:0]   dst;
    logic [LENW-1:0] cnt;
    logic [DW-1:0]   data;
    logic            last_word;

    assign last_word = (cnt == LENW'(1));
    assign busy      = (state != ST_IDLE);

    // request held by the state until ready
    assign req.rd   = (state == ST_RD);
    assign req.wr   = (state == ST_WR);
    assign req.addr = (state == ST_RD) ? src : dst;
    assign req.wdat = data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                ST_IDLE:
                    if (start)
                        state <= ST_RD;
                ST_RD:
                    if (res.ready) begin
                        // denied read ends the copy
                        if (res.err) begin
                            state <= ST_IDLE;
                            done  <= 1'b1;
                            err   <= 1'b1;
                        end else begin
                            state <= ST_WR;
                        end
                    end
                ST_WR:
                    if (res.ready) begin
                        if (res.err || last_word) begin
                            state <= ST_IDLE;
                            done  <= 1'b1;
                            err   <= res.err;
                        end else begin
                            state <= ST_RD;
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // addresses, word count and held data
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            src <= cmd.src;
            dst <= cmd.dst;
            cnt <= cmd.len;
        end else if (state == ST_RD && res.ready) begin
            data <= res.rdat;
        end else if (state == ST_WR && res.ready) begin
            src <= src + 1'b1;
            dst <= dst + 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* source/sce_fill.sv */
// ----------------------------------------------------------------------
// fill engine, writes cmd.value over dst to dst+len-1
// write-only channel, cmd.len must be 1 to 256, addresses wrap
// stops at the first err response, start is ignored while busy
// ----------------------------------------------------------------------
module sce_fill
    import sce_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  fill_cmd_t cmd,
    output chnlreq_t  req,
    input  chnlres_t  res,
    output logic      busy,
    output logic      done,
    output logic      err
);

    logic [AW-1:0]   dst;
    logic [LENW-1:0] cnt;
    logic [DW-1:0]   value;
    logic            finish;

    // last word written or a denial
    assign finish = busy && res.ready && (res.err || cnt == LENW'(1));

    assign req.rd   = 1'b0;
    assign req.wr   = busy;
    assign req.addr = dst;
    assign req.wdat = value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            err  <= 1'b0;
        end else begin
            done <= finish;
            err  <= finish && res.err;
            if (!busy && start)
                busy <= 1'b1;
            else if (finish)
                busy <= 1'b0;
        end
    end

    // command latch, then one step per accepted word
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            dst   <= cmd.dst;
            cnt   <= cmd.len;
            value <= cmd.value;
        end else if (busy && res.ready) begin
            dst <= dst + 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* source/sce_top.sv */
// ----------------------------------------------------------------------
// engine top: host channel, copy and fill engines sharing one RAM
// secmode is a plain level, change it only with the channels idle
// all blocks run on the extended reset, sce_ready mirrors it
// ----------------------------------------------------------------------
module sce_top
    import sce_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               soft_reset,
    input  logic               secmode,
    input  logic               ram_clr,
    input  chnlreq_t           host_req,
    output chnlres_t           host_res,
    input  logic               copy_start,
    input  xfer_cmd_t          copy_cmd,
    output logic               copy_busy,
    output logic               copy_done,
    output logic               copy_err,
    input  logic               fill_start,
    input  fill_cmd_t          fill_cmd,
    output logic               fill_busy,
    output logic               fill_done,
    output logic               fill_err,
    output logic [CHNLCNT-1:0] acerr,
    output logic               ram_clr_busy,
    output logic               sce_ready
);

    logic                   sce_rst_n;
    chnlreq_t [CHNLCNT-1:0] ch_req;
    chnlres_t [CHNLCNT-1:0] ch_res;
    chnlreq_t [CHNLCNT-1:0] mc_req;
    chnlres_t [CHNLCNT-1:0] mc_res;
    logic     [AW-1:0]      ram_addr;
    logic                   ram_rd;
    logic                   ram_wr;
    logic     [DW-1:0]      ram_wdat;
    logic     [DW-1:0]      ram_rdat;

    sce_resetgen u_resetgen (
        .clk        (clk),
        .arst_n     (arst_n),
        .soft_reset (soft_reset),
        .rst_n      (sce_rst_n)
    );

    assign sce_ready = sce_rst_n;

    // host channel straight from the ports
    assign ch_req[CH_HOST] = host_req;
    assign host_res        = ch_res[CH_HOST];

    sce_copy u_copy (
        .clk    (clk),
        .arst_n (sce_rst_n),
        .start  (copy_start),
        .cmd    (copy_cmd),
        .req    (ch_req[CH_COPY]),
        .res    (ch_res[CH_COPY]),
        .busy   (copy_busy),
        .done   (copy_done),
        .err    (copy_err)
    );

    sce_fill u_fill (
        .clk    (clk),
        .arst_n (sce_rst_n),
        .start  (fill_start),
        .cmd    (fill_cmd),
        .req    (ch_req[CH_FILL]),
        .res    (ch_res[CH_FILL]),
        .busy   (fill_busy),
        .done   (fill_done),
        .err    (fill_err)
    );

    sce_ac u_ac (
        .clk     (clk),
        .arst_n  (sce_rst_n),
        .secmode (secmode),
        .in_req  (ch_req),
        .in_res  (ch_res),
        .out_req (mc_req),
        .out_res (mc_res),
        .acerr   (acerr)
    );

    sce_memc u_memc (
        .clk      (clk),
        .arst_n   (sce_rst_n),
        .req      (mc_req),
        .res      (mc_res),
        .ram_addr (ram_addr),
        .ram_rd   (ram_rd),
        .ram_wr   (ram_wr),
        .ram_wdat (ram_wdat),
        .ram_rdat (ram_rdat),
        .clr_busy (ram_clr_busy)
    );

    sce_ram u_ram (
        .clk      (clk),
        .arst_n   (sce_rst_n),
        .addr     (ram_addr),
        .rd       (ram_rd),
        .wr       (ram_wr),
        .wdat     (ram_wdat),
        .rdat     (ram_rdat),
        .clr      (ram_clr),
        .clr_busy (ram_clr_busy)
    );

endmodule

/* bench/sce_tb_tests.svh */
// ----------------------------------------------------------------------
// test sequences of sce_tb, included inside the module
// ranges are chosen per segment so that engines and host never touch
// the same word while they run together
// ----------------------------------------------------------------------

task automatic test_reset();
    int e0;
    int n;
    e0 = errors;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    wait_ready(n);
    check_value(n == EXTCNT, $sformatf("sce_ready rose after %0d cycles", n));
    // soft reset drops sce_ready at once
    @(negedge clk);
    soft_reset = 1'b1;
    @(negedge clk);
    check_value(!sce_ready, "sce_ready high during soft reset");
    repeat (3) @(negedge clk);
    soft_reset = 1'b0;
    wait_ready(n);
    check_value(n == EXTCNT, $sformatf("sce_ready back after %0d cycles", n));
    end_test("reset extension", e0);
endtask

task automatic test_host();
    int            e0;
    int            n;
    logic [AW-1:0] a;
    e0 = errors;
    // known contents first
    pulse_clear();
    count_clear(n);
    repeat (24)
        write_random(0, AW, a);
    check_all();
    end_test("host access", e0);
endtask

task automatic test_engines();
    int            e0;
    int            c0;
    int            f0;
    logic [AW-1:0] a;
    xfer_cmd_t     cc;
    fill_cmd_t     fc;
    e0 = errors;
    c0 = copy_dones;
    f0 = fill_dones;
    // fill in segment 3, copy 0 to 1, host in 2
    fc.dst   = AW'(192 + rand_bits(5));
    fc.len   = LENW'(1 + rand_bits(5));
    fc.value = rand_bits(DW);
    cc.src   = AW'(rand_bits(5));
    cc.dst   = AW'(64 + rand_bits(5));
    cc.len   = LENW'(1 + rand_bits(5));
    for (int i = 0; i < int'(fc.len); i++)
        sb[AW'(fc.dst + i)] = fc.value;
    mirror_copy(cc);
    start_engines(1'b1, cc, 1'b1, fc);
    fork
        repeat (16)
            write_random(128, 6, a);
        wait_engines(c0 + 1, f0 + 1);
    join
    check_all();
    check_value(copy_dones == c0 + 1 && fill_dones == f0 + 1, "done pulse count");
    check_value(!copy_err_seen && !fill_err_seen, "engine ended with err");
    end_test("copy and fill", e0);
endtask

task automatic test_access();
    int            e0;
    int            c0;
    int            k0;
    logic [AW-1:0] a;
    xfer_cmd_t     cc;
    e0 = errors;
    c0 = copy_dones;
    k0 = acerr_cnt[CH_COPY];
    @(negedge clk);
    secmode = 1'b1;
    // host may not touch segment 3
    host_write(AW'(192 + rand_bits(6)), rand_bits(DW));
    check_value(last_res.err && last_acerr, "host write to segment 3 not denied");
    // segments 0 and 1 still open to the host
    write_random(0, 7, a);
    host_read(a);
    check_value(!last_res.err && last_res.rdat === sb[a], "allowed host read");
    // copy into segment 0, stopped at its first write
    cc.src = AW'(64 + rand_bits(5));
    cc.dst = AW'(rand_bits(5));
    cc.len = LENW'(8);
    start_engines(1'b1, cc, 1'b0, '0);
    wait_engines(c0 + 1, fill_dones);
    check_value(copy_err_seen, "copy into segment 0 ended without err");
    check_value(acerr_cnt[CH_COPY] == k0 + 1, "acerr of the copy channel count");
    // copy within segments 1 and 2
    cc.src = AW'(64 + rand_bits(5));
    cc.dst = AW'(128 + rand_bits(5));
    mirror_copy(cc);
    start_engines(1'b1, cc, 1'b0, '0);
    wait_engines(c0 + 2, fill_dones);
    check_value(!copy_err_seen, "allowed copy ended with err");
    @(negedge clk);
    secmode = 1'b0;
    check_all();
    end_test("access control", e0);
endtask

task automatic test_clear();
    int e0;
    int n;
    bit swept;
    e0    = errors;
    swept = 1'b0;
    pulse_clear();
    fork
        begin
            count_clear(n);
            swept = 1'b1;
        end
        begin
            host_read(AW'(rand_bits(AW)));
            check_event(swept, "host read completed while the RAM clear was running");
        end
    join
    check_value(n == RAMDEPTH, $sformatf("ram_clr_busy high for %0d cycles", n));
    check_all();
    end_test("ram clear", e0);
endtask

/* bench/sce_tb.sv */
// ----------------------------------------------------------------------
// testbench for sce_top with inputs driven on the falling clock edge
// a scoreboard mirrors the RAM
// the RAM is cleared before first use
// the run is cut off after TIMEOUT clocks
// ----------------------------------------------------------------------
module sce_tb
    import sce_pkg::*;
();

    localparam int          TIMEOUT   = 12000;
    localparam logic [31:0] SEED      = 32'h1d4e103a;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;

    logic               clk;
    logic               arst_n;
    logic               soft_reset;
    logic               secmode;
    logic               ram_clr;
    chnlreq_t           host_req;
    chnlres_t           host_res;
    logic               copy_start;
    xfer_cmd_t          copy_cmd;
    logic               copy_busy;
    logic               copy_done;
    logic               copy_err;
    logic               fill_start;
    fill_cmd_t          fill_cmd;
    logic               fill_busy;
    logic               fill_done;
    logic               fill_err;
    logic [CHNLCNT-1:0] acerr;
    logic               ram_clr_busy;
    logic               sce_ready;

    logic [31:0]   lfsr;
    logic [DW-1:0] sb [RAMDEPTH];
    int            cycles;
    int            checks;
    int            errors;
    int            tests;
    int            copy_dones;
    int            fill_dones;
    int            acerr_cnt [CHNLCNT];
    logic          copy_err_seen;
    logic          fill_err_seen;
    chnlres_t      last_res;
    logic          last_acerr;

    sce_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // engine end pulses and denial strobes
    always @(negedge clk) begin
        if (copy_done) begin
            copy_err_seen = copy_err;
            copy_dones++;
        end
        if (fill_done) begin
            fill_err_seen = fill_err;
            fill_dones++;
        end
        for (int i = 0; i < CHNLCNT; i++)
            if (acerr[i])
                acerr_cnt[i]++;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic bit outputs_idle();
        return !(copy_busy || copy_done || copy_err || fill_busy || fill_done
                 || fill_err || ram_clr_busy || host_res.ready || (|acerr));
    endfunction

    task automatic check_value(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED at time %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic check_event(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s finished, %0d errors", tests, name, errors - errs_before);
    endtask

    // one host access held until ready
    task automatic host_access(input logic rd, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdat);
        @(negedge clk);
        host_req.rd   = rd;
        host_req.wr   = !rd;
        host_req.addr = addr;
        host_req.wdat = wdat;
        do
            @(negedge clk);
        while (!host_res.ready);
        last_res   = host_res;
        last_acerr = acerr[CH_HOST];
        host_req   = '0;
    endtask

    task automatic host_write(input logic [AW-1:0] addr, input logic [DW-1:0] wdat);
        host_access(1'b0, addr, wdat);
    endtask

    task automatic host_read(input logic [AW-1:0] addr);
        host_access(1'b1, addr, '0);
    endtask

    // random word to base plus a random offset and no err expected
    task automatic write_random(input int base, input int bits, output logic [AW-1:0] a);
        logic [DW-1:0] d;
        a = AW'(base + rand_bits(bits));
        d = rand_bits(DW);
        host_write(a, d);
        check_value(!last_res.err, $sformatf("host write to %0d denied", a));
        sb[a] = d;
    endtask

    task automatic check_all();
        for (int a = 0; a < RAMDEPTH; a++) begin
            host_read(AW'(a));
            check_value(!last_res.err && last_res.rdat === sb[a],
                $sformatf("word %0d read %h, expected %h", a, last_res.rdat, sb[a]));
        end
    endtask

    task automatic start_engines(input bit go_copy, input xfer_cmd_t cc,
                                 input bit go_fill, input fill_cmd_t fc);
        @(negedge clk);
        copy_cmd   = cc;
        copy_start = go_copy;
        fill_cmd   = fc;
        fill_start = go_fill;
        @(negedge clk);
        copy_start = 1'b0;
        fill_start = 1'b0;
        check_value((copy_busy || !go_copy) && (fill_busy || !go_fill),
            "engine not busy in the cycle after start");
    endtask

    // running done totals must reach the goals and not pass them
    task automatic wait_engines(input int copy_goal, input int fill_goal);
        int n;
        n = 0;
        while ((copy_dones < copy_goal || fill_dones < fill_goal) && n < 2000) begin
            @(negedge clk);
            n++;
        end
        check_event(copy_dones == copy_goal,
            $sformatf("copy engine gave %0d done pulses in total, expected %0d",
                      copy_dones, copy_goal));
        check_event(fill_dones == fill_goal,
            $sformatf("fill engine gave %0d done pulses in total, expected %0d",
                      fill_dones, fill_goal));
    endtask

    task automatic mirror_copy(input xfer_cmd_t cc);
        for (int i = 0; i < int'(cc.len); i++)
            sb[AW'(cc.dst + i)] = sb[AW'(cc.src + i)];
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        ram_clr = 1'b1;
        @(negedge clk);
        ram_clr = 1'b0;
    endtask

    // count ram_clr_busy cycles then zero the mirror
    task automatic count_clear(output int n);
        n = 0;
        while (ram_clr_busy && n <= 2 * RAMDEPTH) begin
            n++;
            @(negedge clk);
        end
        for (int a = 0; a < RAMDEPTH; a++)
            sb[a] = '0;
    endtask

    // count cycles until sce_ready and check outputs on the way
    task automatic wait_ready(output int n);
        n = 0;
        while (!sce_ready && n <= 2 * EXTCNT) begin
            check_value(outputs_idle(), "outputs active while sce_ready is low");
            @(negedge clk);
            n++;
        end
        check_value(outputs_idle(), "outputs active just after sce_ready rose");
    endtask

    `include "sce_tb_tests.svh"

    initial begin
        arst_n        = 1'b0;
        soft_reset    = 1'b0;
        secmode       = 1'b0;
        ram_clr       = 1'b0;
        host_req      = '0;
        copy_start    = 1'b0;
        copy_cmd      = '0;
        fill_start    = 1'b0;
        fill_cmd      = '0;
        lfsr          = SEED;
        cycles        = 0;
        checks        = 0;
        errors        = 0;
        tests         = 0;
        copy_dones    = 0;
        fill_dones    = 0;
        acerr_cnt     = '{default: 0};
        copy_err_seen = 1'b0;
        fill_err_seen = 1'b0;
        test_reset();
        test_host();
        test_engines();
        test_access();
        test_clear();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
source/sce_pkg.sv
source/sce_resetgen.sv
source/sce_ac.sv
source/sce_memc.sv
source/sce_ram.sv
source/sce_copy.sv
source/sce_fill.sv
source/sce_top.sv
bench/sce_tb.sv
